/* src.f */
common/core_pkg.sv
rtl/core_settings.sv
rtl/core_readback.sv
xbar/xbar_route.sv
xbar/xbar_switch.sv
rtl/sdr_core.sv
sim/tb_sdr_core.sv

/* Bender.yml */
package:
  name: sdr_core

sources:
  - common/core_pkg.sv
  - rtl/core_settings.sv
  - rtl/core_readback.sv
  - xbar/xbar_route.sv
  - xbar/xbar_switch.sv
  - rtl/sdr_core.sv
  - target: test
    files:
      - sim/tb_sdr_core.sv

/* sim/tb_sdr_core.sv */
`timescale 1ns/100ps
////////////////////
// testbench for sdr_core, register access through tables
// then packet routing, concurrency and back-pressure on the switch
////////////////////

module tb_sdr_core;

  localparam int          p_data_w   = 64;
  localparam logic [31:0] build_hash = 32'h1b2e_77c4;
  localparam logic [3:0]  tcxo_val   = 4'h9;
  localparam int          max_wait   = 200;
  localparam int          n_reg_rows = 7;
  localparam int          n_pkt_rows = 7;

  typedef struct packed {
    logic [31:0] addr;
    logic [31:0] data;
    logic [4:0]  sel;
    logic [31:0] exp;
    logic [4:0]  ctl;
  } reg_row_t;

  typedef struct packed {
    core_pkg::port_e src;
    logic [7:0]      addr;
    logic            dport;
    logic [3:0]      len;
    core_pkg::port_e exp;
  } pkt_row_t;

  logic                bus_clk;
  logic                bus_rst;
  logic                i_set_stb;
  logic [31:0]         i_set_addr;
  logic [31:0]         i_set_data;
  logic [3:0]          i_tcxo_status;
  logic [1:0]          i_lock_signals;
  logic [31:0]         o_rb_data;
  logic [1:0]          o_pps_select;
  logic                o_mimo;
  logic                o_codec_arst;
  logic                o_spi_select;
  logic [p_data_w-1:0] i_h2s_tdata;
  logic                i_h2s_tlast;
  logic                i_h2s_tvalid;
  logic                o_h2s_tready;
  logic [p_data_w-1:0] o_s2h_tdata;
  logic                o_s2h_tlast;
  logic                o_s2h_tvalid;
  logic                i_s2h_tready;
  logic [p_data_w-1:0] i_ri_tdata;
  logic                i_ri_tlast;
  logic                i_ri_tvalid;
  logic                o_ri_tready;
  logic [p_data_w-1:0] o_ro_tdata;
  logic                o_ro_tlast;
  logic                o_ro_tvalid;
  logic                i_ro_tready;

  reg_row_t            reg_tab [n_reg_rows];
  pkt_row_t            pkt_tab [n_pkt_rows];
  // one packet slot per source port
  logic [p_data_w-1:0] pkt_beat [2][8];
  int                  pkt_len [2];
  core_pkg::port_e     pkt_exp [2];
  logic [1:0]          slot_busy;
  logic [31:0]         lfsr_q;

  sdr_core #(.p_data_w(p_data_w), .p_build_hash(build_hash)) dut (.*);

  always #10 bus_clk = ~bus_clk;

  ////////////////////
  // random source
  ////////////////////
  function automatic logic rand_bit();
    logic b;
    b      = lfsr_q[0];
    lfsr_q = {1'b0, lfsr_q[31:1]} ^ (b ? 32'ha300_0000 : 32'h0);
    return b;
  endfunction

  function automatic logic [p_data_w-1:0] rand_bits(input int n);
    logic [p_data_w-1:0] v;
    v = '0;
    for (int k = 0; k < n; k++) begin
      v = {v[p_data_w-2:0], rand_bit()};
    end
    return v;
  endfunction

  ////////////////////
  // checks
  ////////////////////
  task automatic stop_run();
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("** Error at %0t: %s = %h, expected %h", $time, name, got, exp);
      stop_run();
    end
  endtask

  task automatic check_port(input string name, input core_pkg::port_e got,
                            input core_pkg::port_e exp);
    if (got !== exp) begin
      $display("** Error at %0t: %s = %0d, expected %0d", $time, name, got, exp);
      stop_run();
    end
  endtask

  task automatic check_beat(input string name, input logic [p_data_w-1:0] got,
                            input logic got_last, input logic [p_data_w-1:0] exp,
                            input logic exp_last);
    if (got !== exp || got_last !== exp_last) begin
      $display("** Error at %0t: %s = %h last %b, expected %h last %b",
               $time, name, got, got_last, exp, exp_last);
      stop_run();
    end
  endtask

  ////////////////////
  // tables
  ////////////////////
  // rb_misc layout is spi select, tcxo status, pps select
  function automatic logic [31:0] misc_word(input logic spi, input logic [1:0] pps);
    return {25'd0, spi, tcxo_val, pps};
  endfunction

  function automatic reg_row_t reg_row(input logic [10:0] addr, input logic [31:0] data,
                                       input logic [4:0] sel, input logic [31:0] exp,
                                       input logic [4:0] ctl);
    reg_row_t r;
    r.addr = {21'd0, addr};
    r.data = data;
    r.sel  = sel;
    r.exp  = exp;
    r.ctl  = ctl;
    return r;
  endfunction

  function automatic pkt_row_t pkt_row(input core_pkg::port_e src, input logic [7:0] addr,
                                       input logic dport, input logic [3:0] len,
                                       input core_pkg::port_e exp);
    pkt_row_t r;
    r.src   = src;
    r.addr  = addr;
    r.dport = dport;
    r.len   = len;
    r.exp   = exp;
    return r;
  endfunction

  task automatic load_tables();
    // ctl column is spi, codec reset, mimo, pps
    reg_tab[0] = reg_row(core_pkg::sr_test, 32'hcafe_f00d, core_pkg::rb_test,
                         32'hcafe_f00d, 5'b0_0_0_10);
    reg_tab[1] = reg_row(core_pkg::sr_misc, 32'h0000_000d, core_pkg::rb_misc,
                         misc_word(1'b0, 2'b01), 5'b0_1_1_01);
    reg_tab[2] = reg_row(core_pkg::sr_spi, 32'h0000_0001, core_pkg::rb_misc,
                         misc_word(1'b1, 2'b01), 5'b1_1_1_01);
    reg_tab[3] = reg_row(core_pkg::sr_misc, 32'h0000_0006, core_pkg::rb_misc,
                         misc_word(1'b1, 2'b10), 5'b1_0_1_10);
    reg_tab[4] = reg_row(core_pkg::sr_xb_local, 32'h0000_0011, core_pkg::rb_hash,
                         build_hash, 5'b1_0_1_10);
    // selector 7 is not mapped
    reg_tab[5] = reg_row(core_pkg::sr_test, 32'h1357_9bdf, 5'd7,
                         core_pkg::bad_word, 5'b1_0_1_10);
    reg_tab[6] = reg_row(core_pkg::sr_spi, 32'h0000_0000, core_pkg::rb_test,
                         32'h1357_9bdf, 5'b0_0_1_10);
    // local address is 8'h11 from here on
    pkt_tab[0] = pkt_row(core_pkg::port_host, 8'h11, 1'b1, 4'd4, core_pkg::port_radio);
    pkt_tab[1] = pkt_row(core_pkg::port_host, 8'h11, 1'b0, 4'd3, core_pkg::port_host);
    pkt_tab[2] = pkt_row(core_pkg::port_host, 8'h22, 1'b1, 4'd2, core_pkg::port_host);
    pkt_tab[3] = pkt_row(core_pkg::port_radio, 8'h11, 1'b0, 4'd5, core_pkg::port_host);
    pkt_tab[4] = pkt_row(core_pkg::port_radio, 8'h11, 1'b1, 4'd3, core_pkg::port_radio);
    pkt_tab[5] = pkt_row(core_pkg::port_radio, 8'h33, 1'b1, 4'd1, core_pkg::port_host);
    pkt_tab[6] = pkt_row(core_pkg::port_host, 8'h28, 1'b1, 4'd2, core_pkg::port_host);
  endtask

  ////////////////////
  // bus drivers
  ////////////////////
  task automatic write_reg(input logic [10:0] addr, input logic [31:0] data);
    @(posedge bus_clk);
    i_set_stb  <= 1'b1;
    i_set_addr <= {21'd0, addr};
    i_set_data <= data;
    @(posedge bus_clk);
    i_set_stb  <= 1'b0;
  endtask

  function automatic logic [31:0] ctl_now();
    return {27'd0, o_spi_select, o_codec_arst, o_mimo, o_pps_select};
  endfunction

  task automatic build_pkt(input core_pkg::port_e src, input logic [7:0] addr,
                           input logic dport, input int len, input core_pkg::port_e exp);
    int s;
    logic [p_data_w-1:0] tag;
    s = int'(src);
    tag = rand_bits(48);
    pkt_beat[s][0] = {tag[47:0], addr, 7'd0, dport};
    for (int b = 1; b < len; b++) begin
      pkt_beat[s][b] = rand_bits(p_data_w);
    end
    pkt_len[s]   = len;
    pkt_exp[s]   = exp;
    slot_busy[s] = 1'b1;
  endtask

  task automatic drive_src(input core_pkg::port_e src, input logic v,
                           input logic [p_data_w-1:0] d, input logic l);
    if (src == core_pkg::port_host) begin
      i_h2s_tvalid <= v;
      i_h2s_tdata  <= d;
      i_h2s_tlast  <= l;
    end else begin
      i_ri_tvalid <= v;
      i_ri_tdata  <= d;
      i_ri_tlast  <= l;
    end
  endtask

  task automatic send_pkt(input core_pkg::port_e src);
    int s;
    int wait_cyc;
    s = int'(src);
    @(posedge bus_clk);
    for (int b = 0; b < pkt_len[s]; b++) begin
      drive_src(src, 1'b1, pkt_beat[s][b], b == pkt_len[s] - 1);
      wait_cyc = 0;
      @(negedge bus_clk);
      while (!(src == core_pkg::port_host ? o_h2s_tready : o_ri_tready)) begin
        wait_cyc++;
        if (wait_cyc > max_wait) begin
          $display("%s input never accepted a beat", src == core_pkg::port_host ? "host" : "radio");
          stop_run();
        end
        @(negedge bus_clk);
      end
      @(posedge bus_clk);
    end
    drive_src(src, 1'b0, '0, 1'b0);
  endtask

  ////////////////////
  // sinks
  ////////////////////
  task automatic wait_arrival(output core_pkg::port_e got);
    int idle;
    idle = 0;
    @(negedge bus_clk);
    while (!o_s2h_tvalid && !o_ro_tvalid) begin
      idle++;
      if (idle > max_wait) begin
        $display("neither output delivered the packet");
        stop_run();
      end
      @(negedge bus_clk);
    end
    got = o_ro_tvalid ? core_pkg::port_radio : core_pkg::port_host;
  endtask

  // starts and ends at a falling edge
  task automatic recv_pkt(input core_pkg::port_e out, input logic bp);
    int s;
    int b;
    int idle;
    logic done;
    logic is_host;
    logic [p_data_w-1:0] d;
    logic l;
    s = -1;
    b = 0;
    idle = 0;
    done = 1'b0;
    is_host = (out == core_pkg::port_host);
    while (!done) begin
      if (is_host ? (o_s2h_tvalid && i_s2h_tready) : (o_ro_tvalid && i_ro_tready)) begin
        d = is_host ? o_s2h_tdata : o_ro_tdata;
        l = is_host ? o_s2h_tlast : o_ro_tlast;
        if (b == 0) begin
          // header identifies the packet
          for (int k = 0; k < 2; k++) begin
            if (slot_busy[k] && pkt_beat[k][0] == d) s = k;
          end
          if (s < 0) begin
            $display("%s output delivered a packet that was never sent",
                     is_host ? "host" : "radio");
            stop_run();
          end
        end
        check_beat(is_host ? "o_s2h_tdata" : "o_ro_tdata", d, l,
                   pkt_beat[s][b], b == pkt_len[s] - 1);
        b++;
        idle = 0;
        done = l;
      end else begin
        idle++;
        if (idle > max_wait) begin
          $display("%s output never delivered the packet", is_host ? "host" : "radio");
          stop_run();
        end
      end
      @(posedge bus_clk);
      if (is_host) i_s2h_tready <= bp ? rand_bit() : 1'b1;
      else i_ro_tready <= bp ? rand_bit() : 1'b1;
      @(negedge bus_clk);
    end
    check_port("arrival port", out, pkt_exp[s]);
    slot_busy[s] = 1'b0;
  endtask

  ////////////////////
  // main sequence
  ////////////////////
  initial begin
    core_pkg::port_e got;
    logic [1:0] prev_lock;
    logic [1:0] lock_val;
    bus_clk        = 1'b0;
    bus_rst        = 1'b1;
    i_set_stb      = 1'b0;
    i_set_addr     = 32'h0;
    i_set_data     = 32'h0;
    i_tcxo_status  = tcxo_val;
    i_lock_signals = 2'b00;
    i_h2s_tdata    = '0;
    i_h2s_tlast    = 1'b0;
    i_h2s_tvalid   = 1'b0;
    i_s2h_tready   = 1'b1;
    i_ri_tdata     = '0;
    i_ri_tlast     = 1'b0;
    i_ri_tvalid    = 1'b0;
    i_ro_tready    = 1'b1;
    slot_busy      = 2'b00;
    lfsr_q         = 32'h6722_5b13;
    load_tables();
    repeat (3) @(posedge bus_clk);
    bus_rst <= 1'b0;

    // reset values, readback selector starts at rb_misc
    @(negedge bus_clk);
    check_word("control outputs", ctl_now(),
               {27'd0, 1'b0, core_pkg::misc_reset[3:0]});
    check_word("o_rb_data", o_rb_data, misc_word(1'b0, core_pkg::misc_reset[1:0]));
    write_reg(core_pkg::sr_readback, {27'd0, core_pkg::rb_compat});
    @(negedge bus_clk);
    check_word("o_rb_data", o_rb_data, core_pkg::compat_word);
    write_reg(core_pkg::sr_readback, {27'd0, core_pkg::rb_hash});
    @(negedge bus_clk);
    check_word("o_rb_data", o_rb_data, build_hash);

    for (int i = 0; i < n_reg_rows; i++) begin
      write_reg(reg_tab[i].addr[10:0], reg_tab[i].data);
      write_reg(core_pkg::sr_readback, {27'd0, reg_tab[i].sel});
      @(negedge bus_clk);
      check_word("o_rb_data", o_rb_data, reg_tab[i].exp);
      check_word("control outputs", ctl_now(), {27'd0, reg_tab[i].ctl});
    end

    // lock bits, old value after one edge, new one after three
    write_reg(core_pkg::sr_readback, {27'd0, core_pkg::rb_pll});
    prev_lock = 2'b00;
    for (int i = 1; i < 3; i++) begin
      lock_val = i[1:0];
      @(posedge bus_clk);
      i_lock_signals <= lock_val;
      @(posedge bus_clk);
      @(negedge bus_clk);
      check_word("o_rb_data", o_rb_data, {30'd0, prev_lock});
      repeat (2) @(posedge bus_clk);
      @(negedge bus_clk);
      check_word("o_rb_data", o_rb_data, {30'd0, lock_val});
      prev_lock = lock_val;
    end

    // one packet at a time
    for (int i = 0; i < n_pkt_rows; i++) begin
      build_pkt(pkt_tab[i].src, pkt_tab[i].addr, pkt_tab[i].dport,
                pkt_tab[i].len, pkt_tab[i].exp);
      fork
        send_pkt(pkt_tab[i].src);
        begin
          wait_arrival(got);
          recv_pkt(got, 1'b0);
        end
      join
    end

    // crossing packets in flight together
    build_pkt(core_pkg::port_host, 8'h11, 1'b1, 5, core_pkg::port_radio);
    build_pkt(core_pkg::port_radio, 8'h11, 1'b0, 4, core_pkg::port_host);
    fork
      send_pkt(core_pkg::port_host);
      send_pkt(core_pkg::port_radio);
      begin
        @(negedge bus_clk);
        recv_pkt(core_pkg::port_radio, 1'b0);
      end
      begin
        @(negedge bus_clk);
        recv_pkt(core_pkg::port_host, 1'b0);
      end
    join

    // both inputs toward the host under random back-pressure
    for (int i = 0; i < 3; i++) begin
      build_pkt(core_pkg::port_host, 8'h11, 1'b0, 3 + i, core_pkg::port_host);
      build_pkt(core_pkg::port_radio, 8'h5c, 1'b1, 6 - i, core_pkg::port_host);
      fork
        send_pkt(core_pkg::port_host);
        send_pkt(core_pkg::port_radio);
        begin
          @(negedge bus_clk);
          recv_pkt(core_pkg::port_host, 1'b1);
          recv_pkt(core_pkg::port_host, 1'b1);
        end
      join
    end
    @(posedge bus_clk);
    i_s2h_tready <= 1'b1;
    repeat (2) @(posedge bus_clk);

    $display("Test passed");
    $finish;
  end

endmodule

/* rtl/sdr_core.sv */
`timescale 1ns/100ps
////////////////////
// bus-clock side of the sdr core
// settings registers, readback and the host/radio packet switch
////////////////////

module sdr_core #(
  parameter int          p_data_w     = 64,
  parameter logic [31:0] p_build_hash = 32'h5d1c_0a37
) (
  input  logic                bus_clk,
  input  logic                bus_rst,
  input  logic                i_set_stb,
  input  logic [31:0]         i_set_addr,
  input  logic [31:0]         i_set_data,
  input  logic [3:0]          i_tcxo_status,
  input  logic [1:0]          i_lock_signals,
  output logic [31:0]         o_rb_data,
  output logic [1:0]          o_pps_select,
  output logic                o_mimo,
  output logic                o_codec_arst,
  output logic                o_spi_select,
  // host side
  input  logic [p_data_w-1:0] i_h2s_tdata,
  input  logic                i_h2s_tlast,
  input  logic                i_h2s_tvalid,
  output logic                o_h2s_tready,
  output logic [p_data_w-1:0] o_s2h_tdata,
  output logic                o_s2h_tlast,
  output logic                o_s2h_tvalid,
  input  logic                i_s2h_tready,
  // radio side
  input  logic [p_data_w-1:0] i_ri_tdata,
  input  logic                i_ri_tlast,
  input  logic                i_ri_tvalid,
  output logic                o_ri_tready,
  output logic [p_data_w-1:0] o_ro_tdata,
  output logic                o_ro_tlast,
  output logic                o_ro_tvalid,
  input  logic                i_ro_tready
);

  core_pkg::rb_sel_e   rb_sel;
  logic [31:0]         test;
  logic [7:0]          xb_local;
  logic [p_data_w-1:0] h_data;
  logic [p_data_w-1:0] r_data;
  logic                h_last, h_valid, h_ready;
  logic                r_last, r_valid, r_ready;
  core_pkg::port_e     h_dest;
  core_pkg::port_e     r_dest;

  ////////////////////
  // registers and readback
  ////////////////////
  core_settings u_settings (
    .bus_clk(bus_clk), .bus_rst(bus_rst),
    .i_set_stb(i_set_stb), .i_set_addr(i_set_addr), .i_set_data(i_set_data),
    .o_rb_sel(rb_sel), .o_test(test), .o_pps_select(o_pps_select),
    .o_mimo(o_mimo), .o_codec_arst(o_codec_arst),
    .o_spi_select(o_spi_select), .o_xb_local(xb_local)
  );

  core_readback #(.p_build_hash(p_build_hash)) u_readback (
    .bus_clk(bus_clk), .bus_rst(bus_rst),
    .i_rb_sel(rb_sel), .i_test(test), .i_pps_select(o_pps_select),
    .i_spi_select(o_spi_select), .i_tcxo_status(i_tcxo_status),
    .i_lock_signals(i_lock_signals), .o_rb_data(o_rb_data)
  );

  ////////////////////
  // packet switch
  ////////////////////
  xbar_route #(.p_data_w(p_data_w)) u_route_host (
    .bus_clk(bus_clk), .bus_rst(bus_rst), .i_xb_local(xb_local),
    .i_tdata(i_h2s_tdata), .i_tlast(i_h2s_tlast), .i_tvalid(i_h2s_tvalid),
    .i_ready(h_ready), .o_tready(o_h2s_tready),
    .o_data(h_data), .o_last(h_last), .o_valid(h_valid), .o_dest(h_dest)
  );

  xbar_route #(.p_data_w(p_data_w)) u_route_radio (
    .bus_clk(bus_clk), .bus_rst(bus_rst), .i_xb_local(xb_local),
    .i_tdata(i_ri_tdata), .i_tlast(i_ri_tlast), .i_tvalid(i_ri_tvalid),
    .i_ready(r_ready), .o_tready(o_ri_tready),
    .o_data(r_data), .o_last(r_last), .o_valid(r_valid), .o_dest(r_dest)
  );

  xbar_switch #(.p_data_w(p_data_w)) u_switch (
    .bus_clk(bus_clk), .bus_rst(bus_rst),
    .i_data_0(h_data), .i_last_0(h_last), .i_valid_0(h_valid), .i_dest_0(h_dest),
    .i_data_1(r_data), .i_last_1(r_last), .i_valid_1(r_valid), .i_dest_1(r_dest),
    .i_ready_host(i_s2h_tready), .i_ready_radio(i_ro_tready),
    .o_ready_0(h_ready), .o_ready_1(r_ready),
    .o_tdata_host(o_s2h_tdata), .o_tlast_host(o_s2h_tlast),
    .o_tvalid_host(o_s2h_tvalid),
    .o_tdata_radio(o_ro_tdata), .o_tlast_radio(o_ro_tlast),
    .o_tvalid_radio(o_ro_tvalid)
  );

endmodule

/* xbar/xbar_switch.sv */
`timescale 1ns/100ps
////////////////////
// two by two packet switch behind the routers
// round-robin grant per output, locked until tlast
////////////////////

module xbar_switch #(
  parameter int p_data_w = 64
) (
  input  logic                bus_clk,
  input  logic                bus_rst,
  input  logic [p_data_w-1:0] i_data_0,
  input  logic                i_last_0,
  input  logic                i_valid_0,
  input  core_pkg::port_e     i_dest_0,
  input  logic [p_data_w-1:0] i_data_1,
  input  logic                i_last_1,
  input  logic                i_valid_1,
  input  core_pkg::port_e     i_dest_1,
  input  logic                i_ready_host,
  input  logic                i_ready_radio,
  output logic                o_ready_0,
  output logic                o_ready_1,
  output logic [p_data_w-1:0] o_tdata_host,
  output logic                o_tlast_host,
  output logic                o_tvalid_host,
  output logic [p_data_w-1:0] o_tdata_radio,
  output logic                o_tlast_radio,
  output logic                o_tvalid_radio
);

  logic [p_data_w-1:0] in_data [2];
  core_pkg::port_e     in_dest [2];
  logic [1:0]          in_valid;
  logic [1:0]          in_last;
  logic [1:0]          in_ready;
  logic [1:0]          out_ready;
  logic [p_data_w-1:0] out_data [2];
  logic [1:0]          out_valid;
  logic [1:0]          out_last;
  // one-hot of the input each output is serving
  logic [1:0]          gnt_oh [2];

  assign in_data[0] = i_data_0;
  assign in_data[1] = i_data_1;
  assign in_dest[0] = i_dest_0;
  assign in_dest[1] = i_dest_1;
  assign in_valid   = {i_valid_1, i_valid_0};
  assign in_last    = {i_last_1, i_last_0};
  assign out_ready  = {i_ready_radio, i_ready_host};

  ////////////////////
  // per-output arbiter
  ////////////////////
  for (genvar o = 0; o < 2; o++) begin : g_out
    localparam core_pkg::port_e lp_port = core_pkg::port_e'(o);

    core_pkg::sw_state_e state_q;
    core_pkg::port_e     grant_q;
    core_pkg::port_e     prio_q;
    core_pkg::port_e     pick;
    logic [1:0]          req;
    logic                busy;
    logic                xfer;

    assign req[0] = in_valid[0] && (in_dest[0] == lp_port);
    assign req[1] = in_valid[1] && (in_dest[1] == lp_port);
    // preferred input first, else the other one
    assign pick = req[prio_q] ? prio_q : core_pkg::port_e'(~prio_q);
    assign busy = (state_q == core_pkg::sw_busy);
    assign xfer = busy && in_valid[grant_q] && out_ready[o];

    always_ff @(posedge bus_clk) begin
      if (bus_rst) begin
        state_q <= core_pkg::sw_idle;
        grant_q <= core_pkg::port_host;
        prio_q  <= core_pkg::port_host;
      end else begin
        case (state_q)
          core_pkg::sw_idle: begin
            if (|req) begin
              state_q <= core_pkg::sw_busy;
              grant_q <= pick;
              prio_q  <= core_pkg::port_e'(~pick);
            end
          end
          core_pkg::sw_busy: begin
            if (xfer && in_last[grant_q]) begin
              state_q <= core_pkg::sw_idle;
            end
          end
        endcase
      end
    end

    assign gnt_oh[o]    = busy ? (2'b01 << grant_q) : 2'b00;
    assign out_valid[o] = busy && in_valid[grant_q];
    assign out_last[o]  = in_last[grant_q];
    assign out_data[o]  = in_data[grant_q];
  end

  // ready back to each input from whichever output holds it
  assign in_ready[0] = (gnt_oh[0][0] & out_ready[0]) | (gnt_oh[1][0] & out_ready[1]);
  assign in_ready[1] = (gnt_oh[0][1] & out_ready[0]) | (gnt_oh[1][1] & out_ready[1]);

  assign o_ready_0      = in_ready[0];
  assign o_ready_1      = in_ready[1];
  assign o_tdata_host   = out_data[0];
  assign o_tlast_host   = out_last[0];
  assign o_tvalid_host  = out_valid[0];
  assign o_tdata_radio  = out_data[1];
  assign o_tlast_radio  = out_last[1];
  assign o_tvalid_radio = out_valid[1];

  // an input routes to one destination, so both arbiters never hold it
  a_one_grant: assert property (@(posedge bus_clk) disable iff (bus_rst)
    (gnt_oh[0] & gnt_oh[1]) == 2'b00);

endmodule

/* xbar/xbar_route.sv */
`timescale 1ns/100ps
////////////////////
// per-input router for the packet switch
// decodes the header beat and holds the destination until tlast
////////////////////

module xbar_route #(
  parameter int p_data_w = 64
) (
  input  logic                bus_clk,
  input  logic                bus_rst,
  input  logic [7:0]          i_xb_local,
  input  logic [p_data_w-1:0] i_tdata,
  input  logic                i_tlast,
  input  logic                i_tvalid,
  input  logic                i_ready,
  output logic                o_tready,
  output logic [p_data_w-1:0] o_data,
  output logic                o_last,
  output logic                o_valid,
  output core_pkg::port_e     o_dest
);

  core_pkg::route_state_e state_q;
  core_pkg::port_e        dest_q;
  core_pkg::port_e        hdr_dest;
  logic                   xfer;

  assign xfer = i_tvalid && i_ready;

  ////////////////////
  // header decode
  ////////////////////
  // address bits 15..8, port in bit 0
  always_comb begin
    if (i_tdata[15:8] == i_xb_local) begin
      hdr_dest = core_pkg::port_e'(i_tdata[0]);
    end else begin
      hdr_dest = core_pkg::port_host;
    end
  end

  always_ff @(posedge bus_clk) begin
    if (bus_rst) begin
      state_q <= core_pkg::rt_header;
      dest_q  <= core_pkg::port_host;
    end else begin
      case (state_q)
        core_pkg::rt_header: begin
          // single beat packets stay in header state
          if (xfer && !i_tlast) begin
            state_q <= core_pkg::rt_body;
            dest_q  <= hdr_dest;
          end
        end
        core_pkg::rt_body: begin
          if (xfer && i_tlast) begin
            state_q <= core_pkg::rt_header;
          end
        end
      endcase
    end
  end

  // beat passes straight through
  assign o_valid  = i_tvalid;
  assign o_data   = i_tdata;
  assign o_last   = i_tlast;
  assign o_tready = i_ready;
  assign o_dest   = (state_q == core_pkg::rt_header) ? hdr_dest : dest_q;

endmodule

/* rtl/core_readback.sv */
`timescale 1ns/100ps
////////////////////
// readback word selection for the settings bus
// pll lock bits are brought into bus_clk through two flops
////////////////////

module core_readback #(
  parameter logic [31:0] p_build_hash = 32'h0
) (
  input  logic              bus_clk,
  input  logic              bus_rst,
  input  core_pkg::rb_sel_e i_rb_sel,
  input  logic [31:0]       i_test,
  input  logic [1:0]        i_pps_select,
  input  logic              i_spi_select,
  input  logic [3:0]        i_tcxo_status,
  input  logic [1:0]        i_lock_signals,
  output logic [31:0]       o_rb_data
);

  logic [1:0] lock_meta;
  logic [1:0] lock_sync;

  ////////////////////
  // lock synchronizer
  ////////////////////
  always_ff @(posedge bus_clk) begin
    if (bus_rst) begin
      lock_meta <= 2'b00;
      lock_sync <= 2'b00;
    end else begin
      lock_meta <= i_lock_signals;
      lock_sync <= lock_meta;
    end
  end

  ////////////////////
  // readback mux
  ////////////////////
  always_comb begin
    case (i_rb_sel)
      core_pkg::rb_misc: begin
        o_rb_data = {25'd0, i_spi_select, i_tcxo_status, i_pps_select};
      end
      core_pkg::rb_compat: o_rb_data = core_pkg::compat_word;
      core_pkg::rb_hash:   o_rb_data = p_build_hash;
      core_pkg::rb_pll:    o_rb_data = {30'd0, lock_sync};
      core_pkg::rb_test:   o_rb_data = i_test;
      // unmapped selector
      default:             o_rb_data = core_pkg::bad_word;
    endcase
  end

endmodule

/* rtl/core_settings.sv */
`timescale 1ns/100ps
////////////////////
// core control registers written over the strobe settings bus
// a write takes effect on the clock edge after the strobe
////////////////////

module core_settings (
  input  logic              bus_clk,
  input  logic              bus_rst,
  input  logic              i_set_stb,
  input  logic [31:0]       i_set_addr,
  input  logic [31:0]       i_set_data,
  output core_pkg::rb_sel_e o_rb_sel,
  output logic [31:0]       o_test,
  output logic [1:0]        o_pps_select,
  output logic              o_mimo,
  output logic              o_codec_arst,
  output logic              o_spi_select,
  output logic [7:0]        o_xb_local
);

  // only the low address bits are decoded
  logic [10:0] addr;
  logic [31:0] misc_q;

  assign addr = i_set_addr[10:0];

  ////////////////////
  // register file
  ////////////////////
  always_ff @(posedge bus_clk) begin
    if (bus_rst) begin
      o_rb_sel     <= core_pkg::rb_misc;
      o_test       <= 32'h0;
      misc_q       <= core_pkg::misc_reset;
      o_xb_local   <= core_pkg::xb_local_reset;
      o_spi_select <= 1'b0;
    end else if (i_set_stb) begin
      case (addr)
        core_pkg::sr_readback: begin
          o_rb_sel <= core_pkg::rb_sel_e'(i_set_data[4:0]);
        end
        core_pkg::sr_test: begin
          o_test <= i_set_data;
        end
        core_pkg::sr_misc: begin
          misc_q <= i_set_data;
        end
        core_pkg::sr_xb_local: begin
          o_xb_local <= i_set_data[7:0];
        end
        core_pkg::sr_spi: begin
          o_spi_select <= i_set_data[0];
        end
        default: begin
        end
      endcase
    end
  end

  // misc fields
  assign o_pps_select = misc_q[1:0];
  assign o_mimo       = misc_q[2];
  assign o_codec_arst = misc_q[3];

  // a strobe with a floating address would load an arbitrary register
  a_addr_known: assert property (@(posedge bus_clk) disable iff (bus_rst)
    i_set_stb |-> !$isunknown(i_set_addr));

endmodule

/* common/core_pkg.sv */
////////////////////
// shared constants and types for the sdr core
// register offsets, readback selectors, switch ports and FSM states
////////////////////

package core_pkg;

  ////////////////////
  // settings bus offsets
  ////////////////////
  localparam logic [10:0] sr_readback = 11'd0;
  localparam logic [10:0] sr_misc     = 11'd4;
  localparam logic [10:0] sr_test     = 11'd28;
  localparam logic [10:0] sr_xb_local = 11'd32;
  localparam logic [10:0] sr_spi      = 11'd64;

  ////////////////////
  // readback selectors
  ////////////////////
  typedef enum logic [4:0] {
    rb_misc   = 5'd1,
    rb_compat = 5'd2,
    rb_hash   = 5'd3,
    rb_pll    = 5'd4,
    rb_test   = 5'd24
  } rb_sel_e;

  // major 0xac, minor 255
  localparam logic [31:0] compat_word = {8'hac, 8'h00, 8'd255, 8'd0};
  localparam logic [31:0] bad_word    = 32'hdead_beef;

  // pps_select = 2 picks the internal pps
  localparam logic [31:0] misc_reset     = 32'h0000_0002;
  localparam logic [7:0]  xb_local_reset = 8'd40;

  ////////////////////
  // switch types
  ////////////////////
  typedef enum logic [0:0] {
    port_host  = 1'b0,
    port_radio = 1'b1
  } port_e;

  typedef enum logic [0:0] {
    rt_header = 1'b0,
    rt_body   = 1'b1
  } route_state_e;

  typedef enum logic [0:0] {
    sw_idle = 1'b0,
    sw_busy = 1'b1
  } sw_state_e;

endpackage
